// File: lq_macros.svh
`ifndef LQ_MACROS_SVH
`define LQ_MACROS_SVH

// queue geometry
`define LQ_SIZE       8
`define LQ_DISP_W     2

// execution pipes feeding the queue
`define LQ_LSU_PORTS  2

// field widths
`define LQ_CMT_ID_W   5
`define LQ_VADDR_W    39

// miss-queue indices are one-hot of this width
`define LQ_MISSQ_SIZE 4

// entry index width
`define LQ_IDX_W      $clog2(`LQ_SIZE)

`endif

// File: lq_pkg.sv
`include "lq_macros.svh"

package lq_pkg;

  typedef logic [`LQ_IDX_W-1:0] lq_idx_t;

  typedef enum logic [2:0] {
    ST_FREE, ST_ISSUED, ST_TLB_HAZ, ST_RUN, ST_MISSQ_HAZ, ST_DONE
  } lq_state_t;

  typedef enum logic [1:0] {
    HAZ_NONE, HAZ_MISSQ_CONFLICT, HAZ_MISSQ_FULL, HAZ_MISSQ_ASSIGNED
  } lq_haz_t;

  // load flavours carried with each dispatch slot
  typedef enum logic [2:0] {
    OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU
  } lq_op_t;

  typedef struct packed {
    logic [`LQ_DISP_W-1:0]   valid;
    logic [`LQ_CMT_ID_W-1:0] cmt_id;  // shared by the whole group
    lq_op_t [`LQ_DISP_W-1:0] op;
  } lq_disp_t;

  typedef struct packed {
    logic                    valid;
    logic [`LQ_CMT_ID_W-1:0] cmt_id;
    logic [`LQ_DISP_W-1:0]   grp_id;  // one-hot slot
  } lq_alloc_t;

  typedef struct packed {
    logic                    update;
    logic [`LQ_CMT_ID_W-1:0] cmt_id;
    logic [`LQ_DISP_W-1:0]   grp_id;
    logic                    tlb_miss;
    logic [`LQ_VADDR_W-1:0]  vaddr;
  } lq_ex1_upd_t;

  typedef struct packed {
    logic                      update;
    lq_idx_t                   index;
    lq_haz_t                   hazard;
    logic [`LQ_MISSQ_SIZE-1:0] missq_oh;
  } lq_ex2_upd_t;

  typedef struct packed {
    logic                      valid;
    logic [`LQ_MISSQ_SIZE-1:0] index_oh;
  } lq_missq_resolve_t;

  typedef struct packed {
    logic                    valid;
    logic [`LQ_CMT_ID_W-1:0] cmt_id;
    logic [`LQ_DISP_W-1:0]   grp_id;
    logic [`LQ_VADDR_W-1:0]  vaddr;
  } lq_done_rpt_t;

  typedef struct packed {
    logic [`LQ_CMT_ID_W-1:0] cmt_id;
    logic [`LQ_DISP_W-1:0]   grp_id;
  } lq_entry_tag_t;

endpackage

// File: lq_alloc.sv
`timescale 1ns/1ps
`include "lq_macros.svh"

module lq_alloc
  import lq_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  lq_disp_t  i_disp,
  input  logic      i_retire,
  output lq_alloc_t o_alloc [`LQ_SIZE],
  output logic      o_disp_ready,
  output lq_idx_t   o_head_ptr
);

  localparam int CNT_W = $clog2(`LQ_SIZE + 1);

  lq_idx_t          r_in_ptr;
  lq_idx_t          r_out_ptr;
  logic [CNT_W-1:0] r_count;     // occupied entries
  logic [CNT_W-1:0] w_disp_num;
  lq_idx_t          w_slot_ptr [`LQ_DISP_W];

  // each valid slot lands after the valid slots before it
  always_comb begin
    w_disp_num = '0;
    for (int s = 0; s < `LQ_DISP_W; s++) begin
      w_slot_ptr[s] = r_in_ptr + lq_idx_t'(w_disp_num);
      w_disp_num    = w_disp_num + CNT_W'(i_disp.valid[s]);
    end
  end

  for (genvar e = 0; e < `LQ_SIZE; e++) begin : g_entry
    logic [`LQ_DISP_W-1:0] w_hit;

    for (genvar s = 0; s < `LQ_DISP_W; s++) begin : g_slot
      assign w_hit[s] = i_disp.valid[s] && (w_slot_ptr[s] == lq_idx_t'(e));
    end

    // at most one slot hits an entry, so the hit vector is the group id
    assign o_alloc[e] = '{valid:  |w_hit,
                          cmt_id: i_disp.cmt_id,
                          grp_id: w_hit};
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
      r_count   <= '0;
    end else begin
      r_in_ptr <= r_in_ptr + lq_idx_t'(w_disp_num);
      if (i_retire) begin
        r_out_ptr <= r_out_ptr + 1'b1;
      end
      r_count <= r_count + w_disp_num - CNT_W'(i_retire);
    end
  end

  // room for a full group
  assign o_disp_ready = (CNT_W'(`LQ_SIZE) - r_count) >= CNT_W'(`LQ_DISP_W);
  assign o_head_ptr   = r_out_ptr;

endmodule

// File: lq_update_match.sv
`timescale 1ns/1ps
`include "lq_macros.svh"

module lq_update_match
  import lq_pkg::*;
(
  input  lq_ex1_upd_t         i_ex1_upd [`LQ_LSU_PORTS],
  input  lq_ex2_upd_t         i_ex2_upd [`LQ_LSU_PORTS],
  input  lq_entry_tag_t       i_tags [`LQ_SIZE],
  output logic [`LQ_SIZE-1:0] o_ex1_hit,
  output lq_ex1_upd_t         o_ex1_sel [`LQ_SIZE],
  output logic [`LQ_SIZE-1:0] o_ex2_hit,
  output lq_ex2_upd_t         o_ex2_sel [`LQ_SIZE]
);

  for (genvar e = 0; e < `LQ_SIZE; e++) begin : g_entry
    logic [`LQ_LSU_PORTS-1:0] w_ex1_match;
    logic [`LQ_LSU_PORTS-1:0] w_ex2_match;
    lq_ex1_upd_t              w_ex1_sel;
    lq_ex2_upd_t              w_ex2_sel;

    for (genvar p = 0; p < `LQ_LSU_PORTS; p++) begin : g_port
      // EX1 finds its load by commit id and slot
      assign w_ex1_match[p] = i_ex1_upd[p].update &&
                              (i_ex1_upd[p].cmt_id == i_tags[e].cmt_id) &&
                              (i_ex1_upd[p].grp_id == i_tags[e].grp_id);
      // EX2 already knows the entry index
      assign w_ex2_match[p] = i_ex2_upd[p].update &&
                              (i_ex2_upd[p].index == lq_idx_t'(e));
    end

    // one-hot OR mux over the ports
    always_comb begin
      w_ex1_sel = '0;
      w_ex2_sel = '0;
      for (int p = 0; p < `LQ_LSU_PORTS; p++) begin
        w_ex1_sel = w_ex1_sel | ({$bits(lq_ex1_upd_t){w_ex1_match[p]}} & i_ex1_upd[p]);
        w_ex2_sel = w_ex2_sel | ({$bits(lq_ex2_upd_t){w_ex2_match[p]}} & i_ex2_upd[p]);
      end
    end

    assign o_ex1_hit[e] = |w_ex1_match;
    assign o_ex2_hit[e] = |w_ex2_match;
    assign o_ex1_sel[e] = w_ex1_sel;
    assign o_ex2_sel[e] = w_ex2_sel;
  end

endmodule

// File: lq_entry_array.sv
`timescale 1ns/1ps
`include "lq_macros.svh"

module lq_entry_array
  import lq_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  lq_alloc_t                i_alloc [`LQ_SIZE],
  input  logic [`LQ_SIZE-1:0]      i_ex1_hit,
  input  lq_ex1_upd_t              i_ex1_sel [`LQ_SIZE],
  input  logic [`LQ_SIZE-1:0]      i_ex2_hit,
  input  lq_ex2_upd_t              i_ex2_sel [`LQ_SIZE],
  input  logic [`LQ_LSU_PORTS-1:0] i_tlb_resolve,
  input  lq_missq_resolve_t        i_missq_resolve,
  input  lq_idx_t                  i_head_ptr,
  output lq_entry_tag_t            o_tags [`LQ_SIZE],
  output logic                     o_retire,
  output lq_done_rpt_t             o_done_report
);

  lq_state_t              w_state [`LQ_SIZE];
  logic [`LQ_VADDR_W-1:0] w_vaddr [`LQ_SIZE];

  for (genvar e = 0; e < `LQ_SIZE; e++) begin : g_entry
    lq_state_t                 r_state;
    lq_entry_tag_t             r_tag;
    logic [`LQ_VADDR_W-1:0]    r_vaddr;
    logic [`LQ_MISSQ_SIZE-1:0] r_missq_oh;
    logic                      w_take;
    logic                      w_ex1;
    logic                      w_ex2;
    logic                      w_free;

    assign w_take = i_alloc[e].valid && (r_state == ST_FREE);
    assign w_ex1  = i_ex1_hit[e] && (r_state == ST_ISSUED);
    assign w_ex2  = i_ex2_hit[e] && (r_state == ST_RUN);
    assign w_free = o_retire && (i_head_ptr == lq_idx_t'(e));

    always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_state <= ST_FREE;
      end else begin
        case (r_state)
          ST_FREE:      if (w_take) r_state <= ST_ISSUED;
          ST_ISSUED:    if (w_ex1) r_state <= i_ex1_sel[e].tlb_miss ? ST_TLB_HAZ : ST_RUN;
          ST_TLB_HAZ:   if (|i_tlb_resolve) r_state <= ST_RUN;  // any port wakes all
          ST_RUN: begin
            if (w_ex2) begin
              r_state <= (i_ex2_sel[e].hazard == HAZ_NONE) ? ST_DONE : ST_MISSQ_HAZ;
            end
          end
          ST_MISSQ_HAZ: begin
            if (i_missq_resolve.valid && (i_missq_resolve.index_oh == r_missq_oh)) begin
              r_state <= ST_RUN;
            end
          end
          ST_DONE:      if (w_free) r_state <= ST_FREE;
          default:      r_state <= ST_FREE;
        endcase
      end
    end

    always_ff @(posedge i_clk) begin
      if (w_take) begin
        r_tag.cmt_id <= i_alloc[e].cmt_id;
        r_tag.grp_id <= i_alloc[e].grp_id;
      end
      if (w_ex1) begin
        r_vaddr <= i_ex1_sel[e].vaddr;
      end
      if (w_ex2) begin
        r_missq_oh <= i_ex2_sel[e].missq_oh;  // only looked at in ST_MISSQ_HAZ
      end
    end

    assign o_tags[e]  = r_tag;
    assign w_state[e] = r_state;
    assign w_vaddr[e] = r_vaddr;
  end

  // head reports as soon as it is done
  assign o_retire = (w_state[i_head_ptr] == ST_DONE);

  always_comb begin
    o_done_report.valid  = o_retire;
    o_done_report.cmt_id = o_tags[i_head_ptr].cmt_id;
    o_done_report.grp_id = o_tags[i_head_ptr].grp_id;
    o_done_report.vaddr  = w_vaddr[i_head_ptr];
  end

endmodule

// File: load_queue_top.sv
`timescale 1ns/1ps
`include "lq_macros.svh"

module load_queue_top
  import lq_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  lq_disp_t                 i_disp,
  output logic                     o_disp_ready,
  input  lq_ex1_upd_t              i_ex1_upd [`LQ_LSU_PORTS],
  input  lq_ex2_upd_t              i_ex2_upd [`LQ_LSU_PORTS],
  input  logic [`LQ_LSU_PORTS-1:0] i_tlb_resolve,
  input  lq_missq_resolve_t        i_missq_resolve,
  output lq_done_rpt_t             o_done_report
);

  lq_alloc_t           w_alloc [`LQ_SIZE];
  lq_entry_tag_t       w_tags [`LQ_SIZE];
  logic [`LQ_SIZE-1:0] w_ex1_hit;
  lq_ex1_upd_t         w_ex1_sel [`LQ_SIZE];
  logic [`LQ_SIZE-1:0] w_ex2_hit;
  lq_ex2_upd_t         w_ex2_sel [`LQ_SIZE];
  logic                w_retire;
  lq_idx_t             w_head_ptr;

  lq_alloc u_alloc (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp       (i_disp),
    .i_retire     (w_retire),
    .o_alloc      (w_alloc),
    .o_disp_ready (o_disp_ready),
    .o_head_ptr   (w_head_ptr)
  );

  // runs beside the allocator on the registered tags
  lq_update_match u_update_match (
    .i_ex1_upd (i_ex1_upd),
    .i_ex2_upd (i_ex2_upd),
    .i_tags    (w_tags),
    .o_ex1_hit (w_ex1_hit),
    .o_ex1_sel (w_ex1_sel),
    .o_ex2_hit (w_ex2_hit),
    .o_ex2_sel (w_ex2_sel)
  );

  lq_entry_array u_entry_array (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_alloc         (w_alloc),
    .i_ex1_hit       (w_ex1_hit),
    .i_ex1_sel       (w_ex1_sel),
    .i_ex2_hit       (w_ex2_hit),
    .i_ex2_sel       (w_ex2_sel),
    .i_tlb_resolve   (i_tlb_resolve),
    .i_missq_resolve (i_missq_resolve),
    .i_head_ptr      (w_head_ptr),
    .o_tags          (w_tags),
    .o_retire        (w_retire),
    .o_done_report   (o_done_report)
  );

endmodule

// File: tb_load_queue.sv
`timescale 1ns/1ps
`include "lq_macros.svh"

module tb_load_queue
  import lq_pkg::*;
();

  localparam int RAND_CYCLES  = 2000;
  localparam int TOTAL_CYCLES = RAND_CYCLES + 600;  // directed tests and drains included

  typedef struct packed {
    lq_state_t                 st;
    logic [`LQ_CMT_ID_W-1:0]   cmt_id;
    logic [`LQ_DISP_W-1:0]     grp_id;
    logic [`LQ_VADDR_W-1:0]    vaddr;
    logic [`LQ_MISSQ_SIZE-1:0] missq_oh;
  } model_entry_t;

  logic                     i_clk;
  logic                     i_reset_n;
  lq_disp_t                 disp;
  lq_ex1_upd_t              ex1_upd [`LQ_LSU_PORTS];
  lq_ex2_upd_t              ex2_upd [`LQ_LSU_PORTS];
  logic [`LQ_LSU_PORTS-1:0] tlb_res;
  lq_missq_resolve_t        mq_res;
  logic                     disp_ready;
  lq_done_rpt_t             done_rpt;

  model_entry_t            mdl [`LQ_SIZE];
  int                      m_in;
  int                      m_out;
  int                      m_count;
  int                      seed;
  int                      err_cnt;
  int                      chk_cnt;
  int                      rep_cnt;   // reports seen on the DUT
  int                      load_cnt;
  int                      err_mark;
  int                      rep_mark;
  int                      load_mark;
  logic [`LQ_CMT_ID_W-1:0] next_cmt;
  bit                      saw_full;

  load_queue_top dut_i (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_disp          (disp),
    .o_disp_ready    (disp_ready),
    .i_ex1_upd       (ex1_upd),
    .i_ex2_upd       (ex2_upd),
    .i_tlb_resolve   (tlb_res),
    .i_missq_resolve (mq_res),
    .o_done_report   (done_rpt)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  initial begin
    #(TOTAL_CYCLES * 40 + 2000);
    $display("timeout: the run did not end within %0d cycles", TOTAL_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic clear_inputs();
    disp    = '0;
    tlb_res = '0;
    mq_res  = '0;
    for (int p = 0; p < `LQ_LSU_PORTS; p++) begin
      ex1_upd[p] = '0;
      ex2_upd[p] = '0;
    end
  endtask

  // one clock edge of the reference queue under the inputs now driven
  task automatic model_step();
    lq_state_t st;
    bit        retire;
    retire = (mdl[m_out].st == ST_DONE);
    for (int e = 0; e < `LQ_SIZE; e++) begin
      st = mdl[e].st;
      for (int p = 0; p < `LQ_LSU_PORTS; p++) begin
        if (st == ST_ISSUED && ex1_upd[p].update && ex1_upd[p].cmt_id == mdl[e].cmt_id &&
            ex1_upd[p].grp_id == mdl[e].grp_id) begin
          mdl[e].st    = ex1_upd[p].tlb_miss ? ST_TLB_HAZ : ST_RUN;
          mdl[e].vaddr = ex1_upd[p].vaddr;
        end
        if (st == ST_RUN && ex2_upd[p].update && int'(ex2_upd[p].index) == e) begin
          mdl[e].st       = (ex2_upd[p].hazard == HAZ_NONE) ? ST_DONE : ST_MISSQ_HAZ;
          mdl[e].missq_oh = ex2_upd[p].missq_oh;
        end
      end
      if (st == ST_TLB_HAZ && |tlb_res) mdl[e].st = ST_RUN;
      if (st == ST_MISSQ_HAZ && mq_res.valid && mq_res.index_oh == mdl[e].missq_oh)
        mdl[e].st = ST_RUN;
    end
    if (retire) begin
      mdl[m_out].st = ST_FREE;
      m_out = (m_out + 1) % `LQ_SIZE;
      m_count--;
    end
    for (int s = 0; s < `LQ_DISP_W; s++) begin
      if (disp.valid[s]) begin
        mdl[m_in].st     = ST_ISSUED;
        mdl[m_in].cmt_id = disp.cmt_id;
        mdl[m_in].grp_id = `LQ_DISP_W'(1) << s;  // one-hot slot
        m_in = (m_in + 1) % `LQ_SIZE;
        m_count++;
      end
    end
  endtask

  // compare this cycle's outputs, step the model, move past the next edge
  task automatic tick();
    model_entry_t head;
    head = mdl[m_out];
    check_val("o_disp_ready", 64'(disp_ready), 64'((`LQ_SIZE - m_count) >= `LQ_DISP_W));
    check_val("o_done_report.valid", 64'(done_rpt.valid), 64'(head.st == ST_DONE));
    if (head.st == ST_DONE) begin
      check_val("o_done_report.cmt_id", 64'(done_rpt.cmt_id), 64'(head.cmt_id));
      check_val("o_done_report.grp_id", 64'(done_rpt.grp_id), 64'(head.grp_id));
      check_val("o_done_report.vaddr", 64'(done_rpt.vaddr), 64'(head.vaddr));
    end
    if (done_rpt.valid) rep_cnt++;
    if (`LQ_SIZE - m_count < `LQ_DISP_W) saw_full = 1'b1;
    model_step();
    @(posedge i_clk);
    #2;
    clear_inputs();
  endtask

  task automatic send_disp(input logic [`LQ_DISP_W-1:0] valid);
    disp.valid  = valid;
    disp.cmt_id = next_cmt;  // unique while in flight
    for (int s = 0; s < `LQ_DISP_W; s++) disp.op[s] = lq_op_t'(3'($unsigned($random(seed)) % 7));
    load_cnt += $countones(valid);
    next_cmt++;
  endtask

  task automatic send_ex1(input int port, input int e, input bit miss);
    ex1_upd[port].update   = 1'b1;
    ex1_upd[port].cmt_id   = mdl[e].cmt_id;
    ex1_upd[port].grp_id   = mdl[e].grp_id;
    ex1_upd[port].tlb_miss = miss;
    ex1_upd[port].vaddr    = `LQ_VADDR_W'({$random(seed), $random(seed)});
  endtask

  task automatic send_ex2(input int port, input int e, input lq_haz_t haz,
                          input logic [`LQ_MISSQ_SIZE-1:0] mq);
    ex2_upd[port].update   = 1'b1;
    ex2_upd[port].index    = lq_idx_t'(e);
    ex2_upd[port].hazard   = haz;
    ex2_upd[port].missq_oh = mq;
  endtask

  // random model entry in a given state or -1
  function automatic int find_entry(input lq_state_t st, input int skip);
    int start;
    int e;
    start = $unsigned($random(seed)) % `LQ_SIZE;
    for (int i = 0; i < `LQ_SIZE; i++) begin
      e = (start + i) % `LQ_SIZE;
      if (mdl[e].st == st && e != skip) return e;
    end
    return -1;
  endfunction

  // finishing mode clears every hazard so the queue drains
  task automatic rand_stim(input bit allow_disp, input bit finishing);
    int      e;
    int      used;
    lq_haz_t haz;
    if (allow_disp && (`LQ_SIZE - m_count) >= `LQ_DISP_W && ($random(seed) & 1))
      send_disp(`LQ_DISP_W'($unsigned($random(seed)) % 3 + 1));
    used = -1;
    for (int p = 0; p < `LQ_LSU_PORTS; p++) begin
      e = find_entry(ST_ISSUED, used);
      if (e >= 0 && ($random(seed) & 1)) begin
        send_ex1(p, e, finishing ? 1'b0 : ($unsigned($random(seed)) % 4 == 0));
        used = e;
      end
    end
    used = -1;
    for (int p = 0; p < `LQ_LSU_PORTS; p++) begin
      e = find_entry(ST_RUN, used);
      if (e >= 0 && ($random(seed) & 1)) begin
        haz = HAZ_NONE;
        if (!finishing && ($random(seed) & 1)) begin
          haz = lq_haz_t'(2'($unsigned($random(seed)) % 3 + 1));
        end
        send_ex2(p, e, haz, `LQ_MISSQ_SIZE'(1) << ($unsigned($random(seed)) % `LQ_MISSQ_SIZE));
        used = e;
      end
    end
    if (find_entry(ST_TLB_HAZ, -1) >= 0 && (finishing || $unsigned($random(seed)) % 4 == 0))
      tlb_res = `LQ_LSU_PORTS'(1) << ($unsigned($random(seed)) % `LQ_LSU_PORTS);
    e = find_entry(ST_MISSQ_HAZ, -1);
    if (e >= 0 && (finishing || ($random(seed) & 1))) begin
      mq_res.valid    = 1'b1;
      mq_res.index_oh = `LQ_MISSQ_SIZE'(1) << ($unsigned($random(seed)) % `LQ_MISSQ_SIZE);
      if (finishing || ($random(seed) & 1)) mq_res.index_oh = mdl[e].missq_oh;
    end
  endtask

  task automatic drain(input int max_cycles);
    int n;
    n = 0;
    while (m_count != 0 && n < max_cycles) begin
      rand_stim(1'b0, 1'b1);
      tick();
      n++;
    end
    if (m_count != 0) begin
      $display("queue still holds %0d loads after %0d cycles", m_count, max_cycles);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    check_val("done report count", 64'(rep_cnt - rep_mark), 64'(load_cnt - load_mark));
    $display("%s: %0d loads retired, %0d errors", name, rep_cnt - rep_mark, err_cnt - err_mark);
    err_mark  = err_cnt;
    rep_mark  = rep_cnt;
    load_mark = load_cnt;
  endtask

  initial begin
    int e0;
    int e1;
    seed      = 13;
    err_cnt   = 0;
    chk_cnt   = 0;
    rep_cnt   = 0;
    load_cnt  = 0;
    err_mark  = 0;
    rep_mark  = 0;
    load_mark = 0;
    next_cmt  = '0;
    saw_full  = 1'b0;
    m_in      = 0;
    m_out     = 0;
    m_count   = 0;
    for (int e = 0; e < `LQ_SIZE; e++) mdl[e] = '{st: ST_FREE, default: '0};
    clear_inputs();
    i_reset_n = 1'b0;
    repeat (5) @(posedge i_clk);
    #2;
    i_reset_n = 1'b1;

    check_val("o_disp_ready", 64'(disp_ready), 64'(1));
    check_val("o_done_report.valid", 64'(done_rpt.valid), 64'(0));
    e0 = m_in;
    send_disp(2'b01);
    tick();
    send_ex1(0, e0, 1'b0);
    tick();
    send_ex2(1, e0, HAZ_NONE, '0);
    tick();
    drain(20);
    end_test("single load");

    e0 = m_in;
    send_disp(2'b11);
    tick();
    e1 = m_in;
    send_disp(2'b10);  // slot 1 only
    tick();
    send_ex1(0, e1, 1'b0);
    send_ex1(1, (e0 + 1) % `LQ_SIZE, 1'b0);
    tick();
    send_ex1(0, e0, 1'b0);
    tick();
    send_ex2(0, e1, HAZ_NONE, '0);
    send_ex2(1, (e0 + 1) % `LQ_SIZE, HAZ_NONE, '0);
    tick();
    send_ex2(0, e0, HAZ_NONE, '0);
    tick();
    drain(20);
    end_test("two-slot dispatch");

    e0 = m_in;
    send_disp(2'b01);
    tick();
    send_ex1(1, e0, 1'b1);
    tick();
    send_ex2(0, e0, HAZ_NONE, '0);  // ignored while waiting on the TLB
    tick();
    repeat (3) tick();
    tlb_res = 2'b10;
    tick();
    send_ex2(0, e0, HAZ_NONE, '0);
    tick();
    drain(20);
    end_test("tlb hazard");

    for (int h = 1; h < 4; h++) begin
      e0 = m_in;
      send_disp(2'b01);
      tick();
      send_ex1(0, e0, 1'b0);
      tick();
      send_ex2(0, e0, lq_haz_t'(h), `LQ_MISSQ_SIZE'(1) << h);
      tick();
      mq_res.valid    = 1'b1;
      mq_res.index_oh = `LQ_MISSQ_SIZE'(1);  // some other miss-queue slot
      tick();
      send_ex2(0, e0, HAZ_NONE, '0);  // still waiting, so ignored
      tick();
      tick();
      mq_res.valid    = 1'b1;
      mq_res.index_oh = `LQ_MISSQ_SIZE'(1) << h;
      tick();
      send_ex2(1, e0, HAZ_NONE, '0);
      tick();
      drain(20);
    end
    end_test("miss-queue hazards");

    e0 = m_in;
    send_disp(2'b11);
    tick();
    send_disp(2'b11);
    tick();
    for (int i = 3; i >= 0; i--) begin
      send_ex1(0, (e0 + i) % `LQ_SIZE, 1'b0);
      tick();
    end
    for (int i = 3; i >= 1; i--) begin
      send_ex2(0, (e0 + i) % `LQ_SIZE, HAZ_NONE, '0);
      tick();
    end
    repeat (2) tick();  // younger ones wait behind the head
    send_ex2(0, e0, HAZ_NONE, '0);
    tick();
    drain(20);
    end_test("in-order retirement");

    repeat (RAND_CYCLES) begin
      rand_stim(1'b1, 1'b0);
      tick();
    end
    drain(200);
    check_val("queue full seen", 64'(saw_full), 64'(1));
    end_test("random run");

    $display("%0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+.
lq_pkg.sv
lq_alloc.sv
lq_update_match.sv
lq_entry_array.sv
load_queue_top.sv
tb_load_queue.sv

// File: Makefile
SIM      = verilator
SIMFLAGS = --binary --timing -j 0
TOP      = tb_load_queue
FILELIST = filelist.f
OBJDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf $(OBJDIR)
